/* matmul_pkg.sv */
package matmul_pkg;

  localparam int mat_size = 4;
  localparam int data_width = 8;
  localparam int row_idx_width = $clog2(mat_size);
  // widest memory address the config registers can hold
  localparam int max_addr_width = 10;
  localparam int stride_width = 8;
  localparam int axil_addr_width = 12;

  localparam logic [1:0] axi_resp_okay = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

  typedef struct packed {
    logic                       awvalid;
    logic [axil_addr_width-1:0] awaddr;
    logic                       wvalid;
    logic [31:0]                wdata;
    logic [3:0]                 wstrb;
    logic                       bready;
    logic                       arvalid;
    logic [axil_addr_width-1:0] araddr;
    logic                       rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  // word offsets inside the register block
  typedef enum logic [axil_addr_width-1:0] {
    REG_CTRL   = 12'h000,
    REG_STATUS = 12'h004,
    REG_ADDR_A = 12'h008,
    REG_ADDR_B = 12'h00C,
    REG_ADDR_C = 12'h010,
    REG_STRIDE = 12'h014,
    REG_MASK   = 12'h018
  } reg_offset_e;

  typedef struct packed {
    logic [max_addr_width-1:0] addr_a;
    logic [max_addr_width-1:0] addr_b;
    logic [max_addr_width-1:0] addr_c;
    logic [stride_width-1:0]   stride_a;
    logic [stride_width-1:0]   stride_b;
    logic [stride_width-1:0]   stride_c;
    logic [mat_size-1:0]       mask_a_rows;
    logic [mat_size-1:0]       mask_k;
    logic [mat_size-1:0]       mask_b_cols;
  } mat_cfg_t;

  typedef struct packed {
    logic                                valid;
    logic [row_idx_width-1:0]            row;
    logic [mat_size-1:0][data_width-1:0] elem;
  } c_row_t;

  // base + idx * stride, callers truncate to their own address width
  function automatic logic [max_addr_width-1:0] row_addr(
    input logic [max_addr_width-1:0] base,
    input logic [row_idx_width-1:0]  idx,
    input logic [stride_width-1:0]   stride
  );
    return base + max_addr_width'(idx) * max_addr_width'(stride);
  endfunction

endpackage

/* matmul_ram.sv */
module matmul_ram import matmul_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic                  clk,
  input  logic [addr_width-1:0] addr0,
  input  logic [addr_width-1:0] addr1,
  input  logic [31:0]           d0,
  input  logic [31:0]           d1,
  input  logic [3:0]            we0,
  input  logic [3:0]            we1,
  output logic [31:0]           q0,
  output logic [31:0]           q1
);

  logic [mat_size-1:0][data_width-1:0] mem [2**addr_width];

  // port 1 is written after port 0, so it wins a same-word collision
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < mat_size; lane++) begin
      if (we0[lane]) begin
        mem[addr0][lane] <= d0[lane*data_width +: data_width];
      end
      if (we1[lane]) begin
        mem[addr1][lane] <= d1[lane*data_width +: data_width];
      end
    end
    q0 <= mem[addr0];
    q1 <= mem[addr1];
  end

endmodule

/* matmul_decode.sv */
module matmul_decode import matmul_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  axil_req_t             axil_req,
  output axil_rsp_t             axil_rsp,
  output mat_cfg_t              cfg,
  output logic                  start,
  input  logic                  done_set,
  output logic [addr_width-1:0] host_addr,
  output logic [31:0]           host_wdata,
  output logic [3:0]            host_we_a,
  output logic [3:0]            host_we_b,
  output logic [3:0]            host_we_c,
  input  logic [31:0]           host_rdata_a,
  input  logic [31:0]           host_rdata_b,
  input  logic [31:0]           host_rdata_c
);

  typedef enum logic [1:0] {BUS_IDLE, BUS_WRESP, BUS_RWAIT, BUS_RRESP} bus_state_e;
  // address bits 11:10 pick the register block or one of the memories
  typedef enum logic [1:0] {WIN_REG, WIN_A, WIN_B, WIN_C} win_e;

  bus_state_e  bus_state;
  logic        wr_fire;
  logic        rd_fire;
  win_e        wr_win;
  win_e        rd_win;
  win_e        rd_win_q;
  reg_offset_e wr_off;
  reg_offset_e rd_off;
  logic        wr_reg_hit;
  logic        rd_reg_hit;
  logic [31:0] reg_rdata;
  logic        busy;
  logic        done;
  logic        bvalid_q;
  logic        rvalid_q;
  logic [1:0]  bresp_q;
  logic [1:0]  rresp_q;
  logic [31:0] rdata_q;

  // write wins when both are presented
  assign wr_fire = (bus_state == BUS_IDLE) && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = (bus_state == BUS_IDLE) && axil_req.arvalid &&
                   !axil_req.awvalid && !axil_req.wvalid;

  assign wr_win = win_e'(axil_req.awaddr[11:10]);
  assign rd_win = win_e'(axil_req.araddr[11:10]);
  assign wr_off = reg_offset_e'({axil_req.awaddr[11:2], 2'b00});
  assign rd_off = reg_offset_e'({axil_req.araddr[11:2], 2'b00});

  assign axil_rsp.awready = wr_fire;
  assign axil_rsp.wready  = wr_fire;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.bresp   = bresp_q;
  assign axil_rsp.arready = rd_fire;
  assign axil_rsp.rvalid  = rvalid_q;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = rresp_q;

  ////////////////////////////////////////////////////////////////////////////
  // memory windows, 1 KB each
  ////////////////////////////////////////////////////////////////////////////

  assign host_addr  = wr_fire ? addr_width'(axil_req.awaddr[9:2])
                              : addr_width'(axil_req.araddr[9:2]);
  assign host_wdata = axil_req.wdata;
  assign host_we_a  = (wr_fire && wr_win == WIN_A) ? axil_req.wstrb : 4'b0000;
  assign host_we_b  = (wr_fire && wr_win == WIN_B) ? axil_req.wstrb : 4'b0000;
  assign host_we_c  = (wr_fire && wr_win == WIN_C) ? axil_req.wstrb : 4'b0000;

  ////////////////////////////////////////////////////////////////////////////
  // register block
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (wr_off)
      REG_CTRL, REG_STATUS, REG_ADDR_A, REG_ADDR_B,
      REG_ADDR_C, REG_STRIDE, REG_MASK: wr_reg_hit = 1'b1;
      default: wr_reg_hit = 1'b0;
    endcase
  end

  always_comb begin
    rd_reg_hit = 1'b1;
    reg_rdata  = '0;
    case (rd_off)
      // ctrl bits self-clear, so they always read back zero
      REG_CTRL:   reg_rdata = '0;
      REG_STATUS: reg_rdata = {30'b0, done, busy};
      REG_ADDR_A: reg_rdata = 32'(cfg.addr_a);
      REG_ADDR_B: reg_rdata = 32'(cfg.addr_b);
      REG_ADDR_C: reg_rdata = 32'(cfg.addr_c);
      REG_STRIDE: reg_rdata = 32'({cfg.stride_c, cfg.stride_b, cfg.stride_a});
      REG_MASK:   reg_rdata = 32'({cfg.mask_b_cols, cfg.mask_k, cfg.mask_a_rows});
      default:    rd_reg_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bus_state <= BUS_IDLE;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      start     <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      cfg       <= '0;
    end else begin
      start <= 1'b0;
      case (bus_state)
        BUS_IDLE: begin
          if (wr_fire) begin
            bvalid_q  <= 1'b1;
            bus_state <= BUS_WRESP;
          end else if (rd_fire && rd_win == WIN_REG) begin
            rvalid_q  <= 1'b1;
            bus_state <= BUS_RRESP;
          end else if (rd_fire) begin
            bus_state <= BUS_RWAIT;
          end
        end
        BUS_WRESP: begin
          if (axil_req.bready) begin
            bvalid_q  <= 1'b0;
            bus_state <= BUS_IDLE;
          end
        end
        // memory data arrives one cycle after the address
        BUS_RWAIT: begin
          rvalid_q  <= 1'b1;
          bus_state <= BUS_RRESP;
        end
        BUS_RRESP: begin
          if (axil_req.rready) begin
            rvalid_q  <= 1'b0;
            bus_state <= BUS_IDLE;
          end
        end
        default: bus_state <= BUS_IDLE;
      endcase

      if (wr_fire && wr_win == WIN_REG) begin
        case (wr_off)
          REG_CTRL: begin
            // a new run needs the previous done cleared first
            if (axil_req.wdata[0] && !busy && !done) begin
              start <= 1'b1;
              busy  <= 1'b1;
            end
            if (axil_req.wdata[1]) begin
              done <= 1'b0;
            end
          end
          REG_ADDR_A: cfg.addr_a <= axil_req.wdata[max_addr_width-1:0];
          REG_ADDR_B: cfg.addr_b <= axil_req.wdata[max_addr_width-1:0];
          REG_ADDR_C: cfg.addr_c <= axil_req.wdata[max_addr_width-1:0];
          REG_STRIDE: begin
            cfg.stride_a <= axil_req.wdata[7:0];
            cfg.stride_b <= axil_req.wdata[15:8];
            cfg.stride_c <= axil_req.wdata[23:16];
          end
          REG_MASK: begin
            cfg.mask_a_rows <= axil_req.wdata[mat_size-1:0];
            cfg.mask_k      <= axil_req.wdata[2*mat_size-1:mat_size];
            cfg.mask_b_cols <= axil_req.wdata[3*mat_size-1:2*mat_size];
          end
          default: ;
        endcase
      end

      // last row written, engine goes back to idle
      if (done_set) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp_q <= (wr_win == WIN_REG && !wr_reg_hit) ? axi_resp_slverr : axi_resp_okay;
    end
    if (rd_fire) begin
      rd_win_q <= rd_win;
      rdata_q  <= rd_reg_hit ? reg_rdata : '0;
      rresp_q  <= (rd_win == WIN_REG && !rd_reg_hit) ? axi_resp_slverr : axi_resp_okay;
    end else if (bus_state == BUS_RWAIT) begin
      case (rd_win_q)
        WIN_A:   rdata_q <= host_rdata_a;
        WIN_B:   rdata_q <= host_rdata_b;
        WIN_C:   rdata_q <= host_rdata_c;
        default: rdata_q <= '0;
      endcase
      rresp_q <= axi_resp_okay;
    end
  end

endmodule

/* matmul_execute.sv */
module matmul_execute import matmul_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  mat_cfg_t              cfg,
  input  logic                  start,
  output logic [addr_width-1:0] addr_a,
  output logic [addr_width-1:0] addr_b,
  input  logic [31:0]           rdata_a,
  input  logic [31:0]           rdata_b,
  output c_row_t                c_row
);

  typedef enum logic [1:0] {EX_IDLE, EX_LOAD_B, EX_STREAM_A} ex_state_e;

  ex_state_e                ex_state;
  logic [row_idx_width-1:0] cnt;
  logic                     b_rd_vld;
  logic                     a_rd_vld;
  logic [row_idx_width-1:0] b_rd_idx;
  logic [row_idx_width-1:0] a_rd_idx;

  // b_reg[k][j] is row k, column j of B
  logic [mat_size-1:0][mat_size-1:0][data_width-1:0] b_reg;
  logic [mat_size-1:0][data_width-1:0]               a_elem;
  // prod[j][k] feeds the adder tree of output column j
  logic [mat_size-1:0][mat_size-1:0][data_width-1:0] prod;
  logic [mat_size-1:0][data_width-1:0]               dot;
  logic [mat_size-1:0][data_width-1:0]               row_out;

  // same counter drives both reads, only one is consumed per phase
  assign addr_a = addr_width'(row_addr(cfg.addr_a, cnt, cfg.stride_a));
  assign addr_b = addr_width'(row_addr(cfg.addr_b, cnt, cfg.stride_b));

  ////////////////////////////////////////////////////////////////////////////
  // read sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ex_state <= EX_IDLE;
      cnt      <= '0;
      b_rd_vld <= 1'b0;
      a_rd_vld <= 1'b0;
    end else begin
      b_rd_vld <= (ex_state == EX_LOAD_B);
      a_rd_vld <= (ex_state == EX_STREAM_A);
      case (ex_state)
        EX_IDLE: begin
          if (start) begin
            cnt      <= '0;
            ex_state <= EX_LOAD_B;
          end
        end
        EX_LOAD_B: begin
          cnt <= cnt + 1'b1;
          if (cnt == row_idx_width'(mat_size - 1)) begin
            ex_state <= EX_STREAM_A;
          end
        end
        EX_STREAM_A: begin
          cnt <= cnt + 1'b1;
          if (cnt == row_idx_width'(mat_size - 1)) begin
            ex_state <= EX_IDLE;
          end
        end
        default: ex_state <= EX_IDLE;
      endcase
    end
  end

  // row index tags for the data coming back next cycle
  always_ff @(posedge clk) begin
    b_rd_idx <= cnt;
    a_rd_idx <= cnt;
    if (b_rd_vld) begin
      b_reg[b_rd_idx] <= rdata_b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // 4x4 multiply array
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    a_elem = rdata_a;
    for (int j = 0; j < mat_size; j++) begin
      for (int k = 0; k < mat_size; k++) begin
        // only the low byte of the dot product is kept
        prod[j][k] = cfg.mask_k[k] ? data_width'(a_elem[k] * b_reg[k][j]) : '0;
      end
    end
    for (int j = 0; j < mat_size; j++) begin
      dot[j] = (prod[j][0] + prod[j][1]) + (prod[j][2] + prod[j][3]);
      row_out[j] = (cfg.mask_a_rows[a_rd_idx] && cfg.mask_b_cols[j]) ? dot[j] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      c_row.valid <= 1'b0;
    end else begin
      c_row.valid <= a_rd_vld;
      c_row.row   <= a_rd_idx;
      c_row.elem  <= row_out;
    end
  end

endmodule

/* matmul_result.sv */
module matmul_result import matmul_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  mat_cfg_t              cfg,
  input  c_row_t                c_row,
  output logic [addr_width-1:0] addr_c,
  output logic [31:0]           wdata_c,
  output logic [3:0]            we_c,
  output logic                  done_set
);

  logic [row_idx_width-1:0] row_cnt;

  // the C port has no other writer on port 0, so a row goes out the cycle it lands
  assign addr_c   = addr_width'(row_addr(cfg.addr_c, c_row.row, cfg.stride_c));
  assign wdata_c  = c_row.elem;
  assign we_c     = {mat_size{c_row.valid}};
  assign done_set = c_row.valid && (row_cnt == row_idx_width'(mat_size - 1));

  // rows written in the current run
  always_ff @(posedge clk) begin
    if (!resetn) begin
      row_cnt <= '0;
    end else if (done_set) begin
      row_cnt <= '0;
    end else if (c_row.valid) begin
      row_cnt <= row_cnt + 1'b1;
    end
  end

endmodule

/* matmul_accel.sv */
module matmul_accel import matmul_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic      clk,
  input  logic      resetn,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp
);

  mat_cfg_t              cfg;
  logic                  start;
  logic                  done_set;
  logic [addr_width-1:0] host_addr;
  logic [31:0]           host_wdata;
  logic [3:0]            host_we_a;
  logic [3:0]            host_we_b;
  logic [3:0]            host_we_c;
  logic [31:0]           host_rdata_a;
  logic [31:0]           host_rdata_b;
  logic [31:0]           host_rdata_c;
  logic [addr_width-1:0] addr_a;
  logic [addr_width-1:0] addr_b;
  logic [addr_width-1:0] addr_c;
  logic [31:0]           rdata_a;
  logic [31:0]           rdata_b;
  logic [31:0]           wdata_c;
  logic [3:0]            we_c;
  c_row_t                c_row;

  matmul_decode #(.addr_width(addr_width)) u_decode (
    .clk(clk), .resetn(resetn), .axil_req(axil_req), .axil_rsp(axil_rsp),
    .cfg(cfg), .start(start), .done_set(done_set), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_we_a(host_we_a), .host_we_b(host_we_b),
    .host_we_c(host_we_c), .host_rdata_a(host_rdata_a),
    .host_rdata_b(host_rdata_b), .host_rdata_c(host_rdata_c));

  ////////////////////////////////////////////////////////////////////////////
  // memories, port 0 to the engine and port 1 to the host
  ////////////////////////////////////////////////////////////////////////////

  matmul_ram #(.addr_width(addr_width)) mem_a (
    .clk(clk), .addr0(addr_a), .d0(32'b0), .we0(4'b0000), .q0(rdata_a),
    .addr1(host_addr), .d1(host_wdata), .we1(host_we_a), .q1(host_rdata_a));

  matmul_ram #(.addr_width(addr_width)) mem_b (
    .clk(clk), .addr0(addr_b), .d0(32'b0), .we0(4'b0000), .q0(rdata_b),
    .addr1(host_addr), .d1(host_wdata), .we1(host_we_b), .q1(host_rdata_b));

  // engine only writes C, its read port stays open
  matmul_ram #(.addr_width(addr_width)) mem_c (
    .clk(clk), .addr0(addr_c), .d0(wdata_c), .we0(we_c), .q0(),
    .addr1(host_addr), .d1(host_wdata), .we1(host_we_c), .q1(host_rdata_c));

  matmul_execute #(.addr_width(addr_width)) u_execute (
    .clk(clk), .resetn(resetn), .cfg(cfg), .start(start), .addr_a(addr_a),
    .addr_b(addr_b), .rdata_a(rdata_a), .rdata_b(rdata_b), .c_row(c_row));

  matmul_result #(.addr_width(addr_width)) u_result (
    .clk(clk), .resetn(resetn), .cfg(cfg), .c_row(c_row), .addr_c(addr_c),
    .wdata_c(wdata_c), .we_c(we_c), .done_set(done_set));

endmodule

/* matmul_accel_properties.sv */
module matmul_accel_properties import matmul_pkg::*; (
  input logic      clk,
  input logic      resetn,
  input axil_req_t axil_req,
  input axil_rsp_t axil_rsp,
  input logic      busy,
  input logic      done,
  input logic [3:0] we_c
);

  bvalid_held: assert property (@(posedge clk) disable iff (!resetn)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge clk) disable iff (!resetn)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else $error("rvalid dropped before rready");

  busy_done_exclusive: assert property (@(posedge clk) disable iff (!resetn)
    !(busy && done))
    else $error("busy and done high together");

  // engine writes to C only belong to a run
  c_write_in_run: assert property (@(posedge clk) disable iff (!resetn)
    (we_c != 4'b0000) |-> busy)
    else $error("C memory written while not busy");

endmodule

bind matmul_accel matmul_accel_properties u_props (
  .clk(clk), .resetn(resetn), .axil_req(axil_req), .axil_rsp(axil_rsp),
  .busy(u_decode.busy), .done(u_decode.done), .we_c(we_c));

/* tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int period = 40,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    resetn = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    resetn = 1'b1;
  end

endmodule

/* tb_checker.sv */
module tb_checker import matmul_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic      clk,
  input  logic      resetn,
  input  axil_req_t req,
  input  axil_rsp_t rsp,
  output int        checks,
  output int        errors
);

  localparam int depth = 2 ** addr_width;

  // index 0 is A, 1 is B, 2 is C
  logic [31:0] shadow_mem [3][depth];
  logic [9:0]  addr_reg [3];
  logic [7:0]  stride_reg [3];
  // a rows, shared dimension, b columns
  logic [3:0]  mask_reg [3];
  logic        running;
  logic        done;
  logic [11:0] rd_addr;
  logic [1:0]  bresp_exp;

  initial begin
    checks = 0;
    errors = 0;
  end

  function automatic logic [mat_size-1:0][31:0] matmul_ref(
    input logic [mat_size-1:0][31:0] a_rows,
    input logic [mat_size-1:0][31:0] b_rows,
    input logic [mat_size-1:0]       mask_rows,
    input logic [mat_size-1:0]       mask_k,
    input logic [mat_size-1:0]       mask_cols
  );
    logic [mat_size-1:0][31:0] c_rows;
    logic [data_width-1:0]     acc;
    c_rows = '0;
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        acc = '0;
        for (int k = 0; k < mat_size; k++) begin
          if (mask_k[k]) begin
            acc = acc + a_rows[i][data_width*k +: data_width] *
                        b_rows[k][data_width*j +: data_width];
          end
        end
        if (mask_rows[i] && mask_cols[j]) begin
          c_rows[i][data_width*j +: data_width] = acc;
        end
      end
    end
    return c_rows;
  endfunction

  function automatic int row_index(input logic [9:0] base, input int i, input logic [7:0] stride);
    return (int'(base) + i * int'(stride)) % depth;
  endfunction

  function automatic logic reg_mapped(input logic [11:0] addr);
    return addr[11:10] == 2'b00 && addr[9:2] < 8'd7;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got, input logic [11:0] addr);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t signal %s addr %h expected %h got %h",
               $time, name, addr, exp, got);
    end
  endtask

  // a run is modelled at once, the host only reads C after done
  task automatic fire_start();
    logic [mat_size-1:0][31:0] a_rows;
    logic [mat_size-1:0][31:0] b_rows;
    logic [mat_size-1:0][31:0] c_rows;
    for (int i = 0; i < mat_size; i++) begin
      a_rows[i] = shadow_mem[0][row_index(addr_reg[0], i, stride_reg[0])];
      b_rows[i] = shadow_mem[1][row_index(addr_reg[1], i, stride_reg[1])];
    end
    c_rows = matmul_ref(a_rows, b_rows, mask_reg[0], mask_reg[1], mask_reg[2]);
    for (int i = 0; i < mat_size; i++) begin
      shadow_mem[2][row_index(addr_reg[2], i, stride_reg[2])] = c_rows[i];
    end
  endtask

  task automatic observe_write(input logic [11:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
    int win;
    int idx;
    win = int'(addr[11:10]);
    idx = int'(addr[9:2]) % depth;
    bresp_exp = axi_resp_okay;
    if (win != 0) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) begin
          shadow_mem[win-1][idx][8*lane +: 8] = data[8*lane +: 8];
        end
      end
    end else if (!reg_mapped(addr)) begin
      bresp_exp = axi_resp_slverr;
    end else begin
      case (addr[4:2])
        3'd0: begin
          if (data[0] && !running && !done) begin
            running = 1'b1;
            fire_start();
          end
          if (data[1]) begin
            done = 1'b0;
          end
        end
        3'd2, 3'd3, 3'd4: addr_reg[int'(addr[4:2]) - 2] = data[9:0];
        3'd5: begin
          stride_reg[0] = data[7:0];
          stride_reg[1] = data[15:8];
          stride_reg[2] = data[23:16];
        end
        3'd6: begin
          mask_reg[0] = data[3:0];
          mask_reg[1] = data[7:4];
          mask_reg[2] = data[11:8];
        end
        default: ;
      endcase
    end
  endtask

  task automatic check_read(input logic [11:0] addr, input logic [31:0] got,
                            input logic [1:0] resp);
    int          win;
    logic [31:0] exp;
    win = int'(addr[11:10]);
    exp = '0;
    if (win == 0 && !reg_mapped(addr)) begin
      compare_value("rresp", 32'(axi_resp_slverr), 32'(resp), addr);
    end else begin
      compare_value("rresp", 32'(axi_resp_okay), 32'(resp), addr);
      if (win != 0) begin
        exp = shadow_mem[win-1][int'(addr[9:2]) % depth];
      end else begin
        case (addr[4:2])
          3'd1: begin
            // a running engine may finish at any poll
            if (running && got == 32'h2) begin
              running = 1'b0;
              done    = 1'b1;
            end
            exp = running ? 32'h1 : {30'b0, done, 1'b0};
          end
          3'd2, 3'd3, 3'd4: exp = 32'(addr_reg[int'(addr[4:2]) - 2]);
          3'd5: exp = {8'h00, stride_reg[2], stride_reg[1], stride_reg[0]};
          3'd6: exp = {20'h0, mask_reg[2], mask_reg[1], mask_reg[0]};
          default: exp = '0;
        endcase
      end
      compare_value("rdata", exp, got, addr);
    end
  endtask

  always @(posedge clk) begin
    if (!resetn) begin
      running   = 1'b0;
      done      = 1'b0;
      bresp_exp = axi_resp_okay;
      for (int n = 0; n < 3; n++) begin
        addr_reg[n]   = '0;
        stride_reg[n] = '0;
        mask_reg[n]   = '0;
      end
    end else begin
      if (req.awvalid && req.wvalid && rsp.awready && rsp.wready) begin
        observe_write(req.awaddr, req.wdata, req.wstrb);
      end
      if (rsp.bvalid && req.bready) begin
        compare_value("bresp", 32'(bresp_exp), 32'(rsp.bresp), 12'h000);
      end
      if (req.arvalid && rsp.arready) begin
        rd_addr = req.araddr;
      end
      if (rsp.rvalid && req.rready) begin
        check_read(rd_addr, rsp.rdata, rsp.rresp);
      end
    end
  end

endmodule

/* tb_matmul_accel.sv */
module tb_matmul_accel import matmul_pkg::*; ();

  localparam int addr_width = 8;
  localparam int planned_transactions = 300;
  localparam int timeout_cycles = planned_transactions * 40 + 500;
  localparam int max_polls = 16;
  localparam logic [11:0] win_a = 12'h400;
  localparam logic [11:0] win_c = 12'hC00;

  logic      clk;
  logic      resetn;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  int        chk_checks;
  int        chk_errors;
  int        tb_errors = 0;
  int        cycles = 0;
  int        test_num = 0;
  int        errors_before = 0;

  tb_clock_gen u_clock (.clk(clk), .resetn(resetn));

  matmul_accel #(.addr_width(addr_width)) uut (
    .clk(clk), .resetn(resetn), .axil_req(axil_req), .axil_rsp(axil_rsp));

  tb_checker #(.addr_width(addr_width)) u_checker (
    .clk(clk), .resetn(resetn), .req(axil_req), .rsp(axil_rsp),
    .checks(chk_checks), .errors(chk_errors));

  ////////////////////////////////////////////////////////////////////////////
  // bus driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.bready  = 1'b1;
    do @(posedge clk); while (!axil_rsp.awready);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    do @(posedge clk); while (!axil_rsp.bvalid);
    #1;
    axil_req.bready = 1'b0;
  endtask

  // hold keeps rready low for that many cycles once rvalid is up
  task automatic axil_read(input logic [11:0] addr, output logic [31:0] data, input int hold);
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = (hold == 0);
    do @(posedge clk); while (!axil_rsp.arready);
    #1;
    axil_req.arvalid = 1'b0;
    do @(posedge clk); while (!axil_rsp.rvalid);
    if (hold > 0) begin
      repeat (hold - 1) @(posedge clk);
      #1;
      axil_req.rready = 1'b1;
      @(posedge clk);
    end
    data = axil_rsp.rdata;
    #1;
    axil_req.rready = 1'b0;
  endtask

  function automatic logic [11:0] word_addr(input logic [11:0] win, input int idx);
    return win + 12'(idx * 4);
  endfunction

  task automatic set_config(input int ba, input int bb, input int bc, input int sa,
                            input int sb, input int sc, input logic [11:0] mask);
    axil_write(REG_ADDR_A, 32'(ba), 4'hF);
    axil_write(REG_ADDR_B, 32'(bb), 4'hF);
    axil_write(REG_ADDR_C, 32'(bc), 4'hF);
    axil_write(REG_STRIDE, {8'h00, 8'(sc), 8'(sb), 8'(sa)}, 4'hF);
    axil_write(REG_MASK, 32'(mask), 4'hF);
  endtask

  task automatic load_operands(input int ba, input int sa, input int bb, input int sb);
    for (int i = 0; i < mat_size; i++) begin
      axil_write(word_addr(win_a, ba + i * sa), $urandom(), 4'hF);
      axil_write(word_addr(12'h800, bb + i * sb), $urandom(), 4'hF);
    end
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < max_polls) begin
      axil_read(REG_STATUS, st, 0);
      polls++;
    end
    if (!st[1]) begin
      tb_errors++;
      $display("engine did not report done after %0d status polls", polls);
    end
  endtask

  task automatic read_c_span(input int base, input int count);
    logic [31:0] rd;
    for (int n = 0; n < count; n++) begin
      axil_read(word_addr(win_c, base + n), rd, 0);
    end
  endtask

  task automatic read_cfg();
    logic [31:0] rd;
    for (int off = 8; off <= 24; off += 4) begin
      axil_read(12'(off), rd, 0);
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, chk_errors + tb_errors - errors_before);
    errors_before = chk_errors + tb_errors;
  endtask

  task automatic print_counts();
    $display("tests %0d, checks %0d, errors %0d", test_num, chk_checks, chk_errors + tb_errors);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      tb_errors++;
      $display("run timed out before all tests finished");
      print_counts();
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [11:0] mask;
    int          idx;
    int          ba;
    int          bb;
    int          bc;
    int          sa;
    int          sb;
    int          sc;
    void'($urandom(32'h6fbaf0e9));
    axil_req = '0;
    wait (resetn === 1'b1);

    axil_read(REG_STATUS, rd, 0);
    repeat (2) begin
      axil_write(REG_ADDR_A, $urandom() & 32'h3FF, 4'hF);
      axil_write(REG_ADDR_B, $urandom() & 32'h3FF, 4'hF);
      axil_write(REG_ADDR_C, $urandom() & 32'h3FF, 4'hF);
      axil_write(REG_STRIDE, $urandom() & 32'hFF_FFFF, 4'hF);
      axil_write(REG_MASK, $urandom() & 32'hFFF, 4'hF);
      read_cfg();
    end
    finish_test("register readback");

    // full word first so every lane is known before the partial write
    for (int w = 0; w < 3; w++) begin
      for (int n = 0; n < 4; n++) begin
        idx = $urandom_range(255, 0);
        axil_write(word_addr(12'((w + 1) * 1024), idx), $urandom(), 4'hF);
        axil_write(word_addr(12'((w + 1) * 1024), idx), $urandom(), 4'($urandom()));
        axil_read(word_addr(12'((w + 1) * 1024), idx), rd, 0);
      end
    end
    finish_test("memory windows");

    set_config(0, 0, 0, 1, 1, 1, 12'hFFF);
    load_operands(0, 1, 0, 1);
    axil_write(REG_CTRL, 32'h1, 4'hF);
    wait_done();
    read_c_span(0, 4);
    axil_write(REG_CTRL, 32'h2, 4'hF);
    finish_test("full multiply");

    repeat (2) begin
      ba   = $urandom_range(200, 1);
      bb   = $urandom_range(200, 1);
      bc   = $urandom_range(200, 1);
      sa   = $urandom_range(5, 2);
      sb   = $urandom_range(5, 2);
      sc   = $urandom_range(5, 2);
      mask = 12'($urandom());
      set_config(ba, bb, bc, sa, sb, sc, mask);
      load_operands(ba, sa, bb, sb);
      for (int w = 0; w <= 3 * sc; w++) begin
        axil_write(word_addr(win_c, bc + w), $urandom(), 4'hF);
      end
      axil_write(REG_CTRL, 32'h1, 4'hF);
      wait_done();
      read_c_span(bc, 3 * sc + 1);
      axil_write(REG_CTRL, 32'h2, 4'hF);
    end
    finish_test("masks and strides");

    set_config(8, 8, 64, 1, 1, 1, 12'hFFF);
    load_operands(8, 1, 8, 1);
    axil_write(REG_CTRL, 32'h1, 4'hF);
    axil_write(REG_CTRL, 32'h1, 4'hF);
    wait_done();
    axil_read(REG_STATUS, rd, 0);
    axil_read(REG_STATUS, rd, 0);
    read_c_span(64, 4);
    axil_write(REG_CTRL, 32'h2, 4'hF);
    axil_read(REG_STATUS, rd, 0);
    load_operands(8, 1, 8, 1);
    axil_write(REG_CTRL, 32'h1, 4'hF);
    wait_done();
    axil_write(REG_CTRL, 32'h2, 4'hF);
    read_c_span(64, 4);
    finish_test("control");

    axil_write(12'h01C, $urandom(), 4'hF);
    axil_write(12'h3F0, $urandom(), 4'hF);
    axil_read(12'h020, rd, 0);
    axil_read(12'h3FC, rd, 0);
    read_cfg();
    for (int n = 0; n < 8; n++) begin
      if (n % 2 == 0) begin
        axil_read(word_addr(win_c, 64 + n / 2), rd, $urandom_range(6, 1));
      end else begin
        axil_read(12'(8 + 4 * (n / 2)), rd, $urandom_range(6, 1));
      end
    end
    finish_test("errors and back-pressure");

    print_counts();
    if (chk_errors + tb_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* matmul_accel.f */
matmul_pkg.sv
matmul_ram.sv
matmul_decode.sv
matmul_execute.sv
matmul_result.sv
matmul_accel.sv
matmul_accel_properties.sv
tb_clock_gen.sv
tb_checker.sv
tb_matmul_accel.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_matmul_accel
FILELIST  ?= matmul_accel.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
